// ==== hw/tuple_queue_pkg.sv ====
package tuple_queue_pkg;

    // Queue geometry
    localparam int QUEUE_DEPTH   = 8;
    localparam int TUPLE_WIDTH   = 16;
    localparam int PAYLOAD_WIDTH = 16;

    typedef logic [TUPLE_WIDTH-1:0] tuple_t;

    // One queue slot
    typedef struct packed {
        logic                     valid;
        tuple_t                   tuple;
        logic [PAYLOAD_WIDTH-1:0] payload;
    } entry_t;

    // One bit per slot with index 0 at the head
    typedef logic [QUEUE_DEPTH-1:0] slot_vec_t;

    typedef enum logic {
        OP_INSERT = 1'b0,
        OP_DELETE = 1'b1
    } op_kind_e;

    // Read/write by key
    typedef struct packed {
        logic   rd_en;
        logic   wr_en;
        tuple_t key;
        entry_t wr_entry;
    } access_req_t;

    // Insert at tail or delete by tuple
    typedef struct packed {
        logic     en;
        op_kind_e kind;
        entry_t   entry;
    } queue_op_t;

    typedef struct packed {
        logic   valid;
        logic   hit;
        entry_t entry;
    } read_resp_t;

    typedef struct packed {
        logic   done;
        entry_t entry;
    } deque_resp_t;

    // Sticky error vector
    // Bit 1 is reserved and reads zero
    typedef logic [7:0] error_t;

    localparam int ERR_INSERT_FULL   = 0;
    localparam int ERR_DUPLICATES    = 2;
    localparam int ERR_CORRUPT       = 3;
    localparam int ERR_DEQUE_DELETE  = 4;
    localparam int ERR_DELETE_MISS   = 5;
    localparam int ERR_WRITE_MISS    = 6;
    localparam int ERR_ACCESS_DELETE = 7;

    localparam error_t ERROR_FATAL_MASK = error_t'((1 << ERR_INSERT_FULL)  |
                                                   (1 << ERR_DUPLICATES)   |
                                                   (1 << ERR_CORRUPT)      |
                                                   (1 << ERR_DEQUE_DELETE));

endpackage

// ==== hw/queue_lookup.sv ====
`timescale 1ns/1ps

module queue_lookup (
    input  logic                          clk,
    input  logic                          rst,
    input  tuple_queue_pkg::access_req_t  access,
    input  tuple_queue_pkg::queue_op_t    op,
    input  logic                          deque_en,
    input  tuple_queue_pkg::entry_t       entries [tuple_queue_pkg::QUEUE_DEPTH],
    input  tuple_queue_pkg::slot_vec_t    shift_vec,
    input  tuple_queue_pkg::slot_vec_t    first_empty,
    output tuple_queue_pkg::access_req_t  access_r,
    output tuple_queue_pkg::queue_op_t    op_r,
    output logic                          deque_r,
    output tuple_queue_pkg::slot_vec_t    hit_access,
    output tuple_queue_pkg::slot_vec_t    hit_delete
);

    localparam int DEPTH = tuple_queue_pkg::QUEUE_DEPTH;

    // Entries padded with an empty slot past the tail
    tuple_queue_pkg::entry_t    ent_ext [DEPTH+1];
    // Top bit marks a full queue where an insert can only land after a shift
    logic [DEPTH:0]             fe_ext;
    logic                       pend_insert;
    logic                       access_en;
    logic                       delete_en;
    tuple_queue_pkg::slot_vec_t hit_access_d;
    tuple_queue_pkg::slot_vec_t hit_delete_d;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_ext[i] = entries[i];
        end
        ent_ext[DEPTH] = '0;
    end

    assign fe_ext      = {~|first_empty, first_empty};
    assign pend_insert = op_r.en & (op_r.kind == tuple_queue_pkg::OP_INSERT);
    assign access_en   = access.rd_en | access.wr_en;
    assign delete_en   = op.en & (op.kind == tuple_queue_pkg::OP_DELETE);

    // Compare against the entry each slot holds once stage 1 has
    // applied this cycle's shift and insert
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        tuple_queue_pkg::entry_t src_entry;
        tuple_queue_pkg::tuple_t cand_tuple;
        logic                    src_insert;
        logic                    cand_valid;

        assign src_entry  = shift_vec[i] ? ent_ext[i+1] : ent_ext[i];
        assign src_insert = pend_insert & (shift_vec[i] ? fe_ext[i+1] : fe_ext[i]);
        assign cand_valid = src_insert | src_entry.valid;
        assign cand_tuple = src_insert ? op_r.entry.tuple : src_entry.tuple;

        assign hit_access_d[i] = access_en & cand_valid & (cand_tuple == access.key);
        assign hit_delete_d[i] = delete_en & cand_valid & (cand_tuple == op.entry.tuple);
    end

    // Request registers
    always_ff @(posedge clk) begin
        if (rst) begin
            access_r.rd_en <= 1'b0;
            access_r.wr_en <= 1'b0;
            op_r.en        <= 1'b0;
            deque_r        <= 1'b0;
        end else begin
            access_r <= access;
            op_r     <= op;
            deque_r  <= deque_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_access <= '0;
            hit_delete <= '0;
        end else begin
            hit_access <= hit_access_d;
            hit_delete <= hit_delete_d;
        end
    end

endmodule

// ==== hw/queue_store.sv ====
`timescale 1ns/1ps

module queue_store (
    input  logic                          clk,
    input  logic                          rst,
    input  tuple_queue_pkg::access_req_t  access_r,
    input  tuple_queue_pkg::queue_op_t    op_r,
    input  logic                          deque_r,
    input  tuple_queue_pkg::slot_vec_t    hit_access,
    input  tuple_queue_pkg::slot_vec_t    hit_delete,
    output tuple_queue_pkg::entry_t       entries [tuple_queue_pkg::QUEUE_DEPTH],
    output tuple_queue_pkg::slot_vec_t    shift_vec,
    output tuple_queue_pkg::slot_vec_t    first_empty,
    output logic                          corrupt,
    output logic                          full,
    output logic                          empty
);

    localparam int DEPTH = tuple_queue_pkg::QUEUE_DEPTH;

    tuple_queue_pkg::entry_t    ent_ext [DEPTH+1];
    tuple_queue_pkg::entry_t    next_entry [DEPTH];
    tuple_queue_pkg::entry_t    written;
    tuple_queue_pkg::entry_t    inserted;
    tuple_queue_pkg::slot_vec_t valid_vec;
    tuple_queue_pkg::slot_vec_t valid_inc;
    logic [DEPTH:0]             fe_ext;
    logic [DEPTH:0]             hit_ext;
    logic                       write_en;
    logic                       insert_en;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_ext[i]   = entries[i];
            valid_vec[i] = entries[i].valid;
        end
        ent_ext[DEPTH] = '0;
    end

    // Everything from the head or the deleted slot onward moves left
    always_comb begin
        shift_vec[0] = deque_r | hit_delete[0];
        for (int i = 1; i < DEPTH; i++) begin
            shift_vec[i] = shift_vec[i-1] | hit_delete[i];
        end
    end

    // A packed valid vector is a run of ones from bit 0, so adding one
    // lands exactly on the first empty slot
    assign valid_inc   = valid_vec + 1'b1;
    assign corrupt     = (valid_vec & valid_inc) != '0;
    assign first_empty = corrupt ? '0 : valid_inc;
    assign full        = &valid_vec;
    assign empty       = ~|valid_vec;

    assign fe_ext    = {full, first_empty};
    assign hit_ext   = {1'b0, hit_access};
    assign write_en  = access_r.wr_en;
    assign insert_en = op_r.en & (op_r.kind == tuple_queue_pkg::OP_INSERT);

    // Stored entries are always marked valid
    assign written  = {1'b1, access_r.wr_entry.tuple, access_r.wr_entry.payload};
    assign inserted = {1'b1, op_r.entry.tuple, op_r.entry.payload};

    // Slot priority is write by hit, then insert at first empty, then shift
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        logic src_write;
        logic src_insert;

        assign src_write  = shift_vec[i] ? hit_ext[i+1] : hit_ext[i];
        assign src_insert = shift_vec[i] ? fe_ext[i+1] : fe_ext[i];

        always_comb begin
            if (write_en && src_write) begin
                next_entry[i] = written;
            end else if (insert_en && src_insert) begin
                next_entry[i] = inserted;
            end else if (shift_vec[i]) begin
                next_entry[i] = ent_ext[i+1];
            end else begin
                next_entry[i] = ent_ext[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= next_entry[i];
            end
        end
    end

endmodule

// ==== hw/queue_respond.sv ====
`timescale 1ns/1ps

module queue_respond (
    input  logic                          clk,
    input  logic                          rst,
    input  tuple_queue_pkg::access_req_t  access_r,
    input  tuple_queue_pkg::queue_op_t    op_r,
    input  logic                          deque_r,
    input  tuple_queue_pkg::slot_vec_t    hit_access,
    input  tuple_queue_pkg::slot_vec_t    hit_delete,
    input  tuple_queue_pkg::entry_t       entries [tuple_queue_pkg::QUEUE_DEPTH],
    input  logic                          corrupt,
    input  logic                          full,
    output tuple_queue_pkg::read_resp_t   rd_resp,
    output tuple_queue_pkg::deque_resp_t  dq_resp,
    output logic                          credit_return,
    output tuple_queue_pkg::error_t       error,
    output logic                          error_fatal
);

    localparam int DEPTH = tuple_queue_pkg::QUEUE_DEPTH;

    tuple_queue_pkg::entry_t rd_entry;
    tuple_queue_pkg::entry_t head_entry;
    tuple_queue_pkg::error_t err_set;
    logic                    hit_any;
    logic                    del_any;
    logic                    is_insert;
    logic                    is_delete_op;
    logic                    slot_freed;

    assign hit_any      = |hit_access;
    assign del_any      = |hit_delete;
    assign is_insert    = op_r.en & (op_r.kind == tuple_queue_pkg::OP_INSERT);
    assign is_delete_op = op_r.en & (op_r.kind == tuple_queue_pkg::OP_DELETE);
    assign slot_freed   = (deque_r & entries[0].valid) | del_any;

    // One-hot mux that leaves the result at zero on a miss
    always_comb begin
        rd_entry = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (hit_access[i]) begin
                rd_entry = rd_entry | entries[i];
            end
        end
    end

    // Forward a same-cycle write to the head
    assign head_entry = (access_r.wr_en && hit_access[0]) ?
                        {1'b1, access_r.wr_entry.tuple, access_r.wr_entry.payload} :
                        entries[0];

    always_comb begin
        err_set = '0;
        err_set[tuple_queue_pkg::ERR_INSERT_FULL]   = is_insert & full &
                                                      ~(deque_r | del_any);
        err_set[tuple_queue_pkg::ERR_DUPLICATES]    = ((hit_access & (hit_access - 1'b1)) != '0) |
                                                      ((hit_delete & (hit_delete - 1'b1)) != '0);
        err_set[tuple_queue_pkg::ERR_CORRUPT]       = corrupt;
        err_set[tuple_queue_pkg::ERR_DEQUE_DELETE]  = deque_r & del_any;
        err_set[tuple_queue_pkg::ERR_DELETE_MISS]   = is_delete_op & ~del_any;
        err_set[tuple_queue_pkg::ERR_WRITE_MISS]    = access_r.wr_en & ~hit_any;
        // Access to a slot that is leaving this cycle
        err_set[tuple_queue_pkg::ERR_ACCESS_DELETE] = |(hit_access & hit_delete);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_resp.valid <= 1'b0;
            rd_resp.hit   <= 1'b0;
            dq_resp.done  <= 1'b0;
            credit_return <= 1'b0;
            error         <= '0;
        end else begin
            rd_resp.valid <= access_r.rd_en;
            rd_resp.hit   <= access_r.rd_en & hit_any;
            rd_resp.entry <= access_r.rd_en ? rd_entry : '0;
            dq_resp.done  <= deque_r;
            dq_resp.entry <= head_entry;
            credit_return <= slot_freed;
            error         <= error | err_set;
        end
    end

    assign error_fatal = |(error & tuple_queue_pkg::ERROR_FATAL_MASK);

endmodule

// ==== hw/tuple_queue.sv ====
`timescale 1ns/1ps

module tuple_queue (
    input  logic                          clk,
    input  logic                          rst,
    input  tuple_queue_pkg::access_req_t  access,
    input  tuple_queue_pkg::queue_op_t    op,
    input  logic                          deque_en,
    output tuple_queue_pkg::read_resp_t   rd_resp,
    output tuple_queue_pkg::deque_resp_t  dq_resp,
    output logic                          credit_return,
    output tuple_queue_pkg::error_t       error,
    output logic                          error_fatal,
    output logic                          full,
    output logic                          empty
);

    // Stage 0 outputs
    tuple_queue_pkg::access_req_t access_r;
    tuple_queue_pkg::queue_op_t   op_r;
    logic                         deque_r;
    tuple_queue_pkg::slot_vec_t   hit_access;
    tuple_queue_pkg::slot_vec_t   hit_delete;

    // Stage 1 state
    tuple_queue_pkg::entry_t      entries [tuple_queue_pkg::QUEUE_DEPTH];
    tuple_queue_pkg::slot_vec_t   shift_vec;
    tuple_queue_pkg::slot_vec_t   first_empty;
    logic                         corrupt;

    queue_lookup lookup_inst (
        .clk         (clk),
        .rst         (rst),
        .access      (access),
        .op          (op),
        .deque_en    (deque_en),
        .entries     (entries),
        .shift_vec   (shift_vec),
        .first_empty (first_empty),
        .access_r    (access_r),
        .op_r        (op_r),
        .deque_r     (deque_r),
        .hit_access  (hit_access),
        .hit_delete  (hit_delete)
    );

    queue_store store_inst (
        .clk         (clk),
        .rst         (rst),
        .access_r    (access_r),
        .op_r        (op_r),
        .deque_r     (deque_r),
        .hit_access  (hit_access),
        .hit_delete  (hit_delete),
        .entries     (entries),
        .shift_vec   (shift_vec),
        .first_empty (first_empty),
        .corrupt     (corrupt),
        .full        (full),
        .empty       (empty)
    );

    queue_respond respond_inst (
        .clk           (clk),
        .rst           (rst),
        .access_r      (access_r),
        .op_r          (op_r),
        .deque_r       (deque_r),
        .hit_access    (hit_access),
        .hit_delete    (hit_delete),
        .entries       (entries),
        .corrupt       (corrupt),
        .full          (full),
        .rd_resp       (rd_resp),
        .dq_resp       (dq_resp),
        .credit_return (credit_return),
        .error         (error),
        .error_fatal   (error_fatal)
    );

endmodule

// ==== tests/tuple_queue_properties.sv ====
`timescale 1ns/1ps

module tuple_queue_properties (
    input  logic                          clk,
    input  logic                          rst,
    input  tuple_queue_pkg::queue_op_t    op,
    input  logic                          deque_en,
    input  tuple_queue_pkg::deque_resp_t  dq_resp,
    input  logic                          credit_return,
    input  logic                          full,
    input  logic                          empty
);

    int   credit_fails = 0;
    int   flag_fails   = 0;
    int   done_fails   = 0;
    int   assert_fails;
    logic insert_req;

    assign insert_req   = op.en && (op.kind == tuple_queue_pkg::OP_INSERT);
    assign assert_fails = credit_fails + flag_fails + done_fails;

    // No credit alongside an insert into a full queue
    credit_vs_full: assert property (@(posedge clk) disable iff (rst)
        !(credit_return && insert_req && full))
    else begin
        $error("credit returned while inserting into a full queue");
        credit_fails++;
    end

    full_vs_empty: assert property (@(posedge clk) disable iff (rst)
        !(full && empty))
    else begin
        $error("full and empty are high together");
        flag_fails++;
    end

    // Lookup register plus result register
    done_latency: assert property (@(posedge clk) disable iff (rst)
        dq_resp.done == $past(deque_en, 2))
    else begin
        $error("dq_resp.done does not follow deque_en by two edges");
        done_fails++;
    end

endmodule

// ==== tests/tuple_queue_tb.sv ====
`timescale 1ns/1ps

module tuple_queue_tb;

    localparam int          FIELDS      = 10;
    localparam int          MAX_LINES   = 64;
    localparam int          TIMEOUT     = 20;
    localparam logic [15:0] CODE_INSERT = 16'h1;
    localparam logic [15:0] CODE_DELETE = 16'h2;
    localparam logic [15:0] CODE_READ   = 16'h3;
    localparam logic [15:0] CODE_WRITE  = 16'h4;
    localparam logic [15:0] CODE_DEQUE  = 16'h5;
    localparam logic [15:0] CODE_END    = 16'hf;

    logic                         clk;
    logic                         rst;
    tuple_queue_pkg::access_req_t access;
    tuple_queue_pkg::queue_op_t   op;
    logic                         deque_en;
    tuple_queue_pkg::read_resp_t  rd_resp;
    tuple_queue_pkg::deque_resp_t dq_resp;
    logic                         credit_return;
    tuple_queue_pkg::error_t      error;
    logic                         error_fatal;
    logic                         full;
    logic                         empty;

    logic [15:0] stim [MAX_LINES*FIELDS];
    int          test_ops;
    int          test_fails;
    int          total_ops;
    int          total_fails;
    int          test_count;
    int          cur_op;
    int          credits;
    logic        timed_out;

    tuple_queue tuple_queue_inst (
        .clk           (clk),
        .rst           (rst),
        .access        (access),
        .op            (op),
        .deque_en      (deque_en),
        .rd_resp       (rd_resp),
        .dq_resp       (dq_resp),
        .credit_return (credit_return),
        .error         (error),
        .error_fatal   (error_fatal),
        .full          (full),
        .empty         (empty)
    );

    bind tuple_queue tuple_queue_properties props_inst (
        .clk           (clk),
        .rst           (rst),
        .op            (op),
        .deque_en      (deque_en),
        .dq_resp       (dq_resp),
        .credit_return (credit_return),
        .full          (full),
        .empty         (empty)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_read(input tuple_queue_pkg::read_resp_t got,
                              input tuple_queue_pkg::read_resp_t exp);
        if (got !== exp) begin
            $display("[FAIL] rd_resp = %h, expected %h (operation %0d)", got, exp, cur_op);
            test_fails++;
        end
    endtask

    task automatic check_deque(input tuple_queue_pkg::deque_resp_t got,
                               input tuple_queue_pkg::deque_resp_t exp);
        if (got !== exp) begin
            $display("[FAIL] dq_resp = %h, expected %h (operation %0d)", got, exp, cur_op);
            test_fails++;
        end
    endtask

    task automatic check_error(input tuple_queue_pkg::error_t got,
                               input tuple_queue_pkg::error_t exp);
        if (got !== exp) begin
            $display("[FAIL] error = %h, expected %h (operation %0d)", got, exp, cur_op);
            test_fails++;
        end
    endtask

    task automatic check_credit(input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] credit_return pulses = %h, expected %h (operation %0d)",
                     got, exp, cur_op);
            test_fails++;
        end
    endtask

    // Flags as {error_fatal, full, empty}
    task automatic check_flags(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("[FAIL] {error_fatal, full, empty} = %h, expected %h (operation %0d)",
                     got, exp, cur_op);
            test_fails++;
        end
    endtask

    task automatic clear_inputs();
        access   = '0;
        op       = '0;
        deque_en = 1'b0;
    endtask

    task automatic finish_test(input int id);
        $display("test %0d: %0d operations, %0d mismatches", id, test_ops, test_fails);
        total_ops   += test_ops;
        total_fails += test_fails;
        test_count++;
        test_ops   = 0;
        test_fails = 0;
    endtask

    // Drive one stimulus line on a falling edge and check what comes back
    task automatic run_line(input int base);
        logic [15:0]                  code;
        tuple_queue_pkg::tuple_t      key;
        tuple_queue_pkg::entry_t      exp_entry;
        tuple_queue_pkg::read_resp_t  exp_rd;
        tuple_queue_pkg::deque_resp_t exp_dq;
        int                           seen_credits;
        int                           cycles;
        logic                         done;

        code      = stim[base+1];
        key       = stim[base+2];
        exp_entry = {1'b1, stim[base+5], stim[base+6]};
        test_ops++;
        clear_inputs();
        case (code)
            CODE_INSERT: begin
                op.en    = 1'b1;
                op.kind  = tuple_queue_pkg::OP_INSERT;
                op.entry = {1'b1, key, stim[base+3]};
                credits--;
            end
            CODE_DELETE: begin
                op.en    = 1'b1;
                op.kind  = tuple_queue_pkg::OP_DELETE;
                op.entry = {1'b1, key, stim[base+3]};
            end
            CODE_READ: begin
                access.rd_en = 1'b1;
                access.key   = key;
            end
            CODE_WRITE: begin
                access.wr_en    = 1'b1;
                access.key      = key;
                access.wr_entry = {1'b1, key, stim[base+3]};
            end
            CODE_DEQUE: deque_en = 1'b1;
            default: begin
                $display("unknown operation code %h at operation %0d", code, cur_op);
                test_fails++;
            end
        endcase
        @(negedge clk);
        clear_inputs();

        // Results are registered two edges after the inputs
        seen_credits = 0;
        cycles       = 0;
        done         = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (credit_return) begin
                seen_credits++;
            end
            case (code)
                CODE_READ:  done = rd_resp.valid;
                CODE_DEQUE: done = dq_resp.done;
                default:    done = (cycles == 1);
            endcase
        end
        if (!done) begin
            $display("no response to operation %0d within %0d cycles", cur_op, TIMEOUT);
            test_fails++;
            timed_out = 1'b1;
        end

        if (code == CODE_READ) begin
            exp_rd.valid = 1'b1;
            exp_rd.hit   = stim[base+4][0];
            exp_rd.entry = exp_rd.hit ? exp_entry : '0;
            check_read(rd_resp, exp_rd);
        end
        if (code == CODE_DEQUE) begin
            exp_dq.done  = 1'b1;
            exp_dq.entry = exp_entry;
            check_deque(dq_resp, exp_dq);
        end
        check_credit(seen_credits, int'(stim[base+7]));
        check_error(error, tuple_queue_pkg::error_t'(stim[base+8]));
        check_flags({error_fatal, full, empty}, stim[base+9][2:0]);

        credits += seen_credits;
        if (empty && credits != tuple_queue_pkg::QUEUE_DEPTH) begin
            $display("queue is empty but the producer holds %0d credits", credits);
            test_fails++;
        end
    endtask

    initial begin
        int line;
        int base;
        int cur_test;

        rst = 1'b1;
        clear_inputs();
        test_ops    = 0;
        test_fails  = 0;
        total_ops   = 0;
        total_fails = 0;
        test_count  = 0;
        cur_op      = 0;
        credits     = tuple_queue_pkg::QUEUE_DEPTH;
        timed_out   = 1'b0;
        $readmemh("tests/queue_input.txt", stim);

        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Reset state
        test_ops++;
        check_error(error, '0);
        check_flags({error_fatal, full, empty}, 3'b001);
        if (rd_resp.valid || rd_resp.hit || dq_resp.done || credit_return) begin
            $display("a response flag is high right after reset");
            test_fails++;
        end
        finish_test(0);

        line     = 0;
        cur_test = stim[0];
        while (line < MAX_LINES && !timed_out) begin
            base = line * FIELDS;
            if ($isunknown(stim[base+1]) || stim[base+1] == CODE_END) begin
                break;
            end
            if (stim[base] != cur_test) begin
                finish_test(cur_test);
                cur_test = stim[base];
            end
            cur_op = line + 1;
            run_line(base);
            line++;
        end
        if (test_ops > 0) begin
            finish_test(cur_test);
        end
        if (line == 0) begin
            $display("no stimulus operations were read");
            total_fails++;
        end

        total_fails += tuple_queue_inst.props_inst.assert_fails;
        $display("%0d tests, %0d operations, %0d failures, %0d from assertions",
                 test_count, total_ops, total_fails, tuple_queue_inst.props_inst.assert_fails);
        if (total_fails == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hw/tuple_queue_pkg.sv
hw/queue_lookup.sv
hw/queue_store.sv
hw/queue_respond.sv
hw/tuple_queue.sv
tests/tuple_queue_properties.sv
tests/tuple_queue_tb.sv

// ==== tests/queue_input.txt ====
// test op key payload hit exp_key exp_payload credit error flags{fatal,full,empty}
// op: 1 insert, 2 delete, 3 read, 4 write, 5 deque, f end of stimulus
1 1 1111 a001 0 0000 0000 0 00 0
1 1 2222 a002 0 0000 0000 0 00 0
1 1 3333 a003 0 0000 0000 0 00 0
1 3 1111 0000 1 1111 a001 0 00 0
1 3 2222 0000 1 2222 a002 0 00 0
1 3 3333 0000 1 3333 a003 0 00 0
1 3 4444 0000 0 0000 0000 0 00 0
2 4 2222 b002 0 0000 0000 0 00 0
2 3 2222 0000 1 2222 b002 0 00 0
2 4 5555 b005 0 0000 0000 0 40 0
3 5 0000 0000 0 1111 a001 1 40 0
3 5 0000 0000 0 2222 b002 1 40 0
3 5 0000 0000 0 3333 a003 1 40 1
4 1 4001 c001 0 0000 0000 0 40 0
4 1 4002 c002 0 0000 0000 0 40 0
4 1 4003 c003 0 0000 0000 0 40 0
4 1 4004 c004 0 0000 0000 0 40 0
4 2 4002 0000 0 0000 0000 1 40 0
4 2 9999 0000 0 0000 0000 0 60 0
4 5 0000 0000 0 4001 c001 1 60 0
4 5 0000 0000 0 4003 c003 1 60 0
4 5 0000 0000 0 4004 c004 1 60 1
5 1 5001 d001 0 0000 0000 0 60 0
5 1 5002 d002 0 0000 0000 0 60 0
5 1 5003 d003 0 0000 0000 0 60 0
5 1 5004 d004 0 0000 0000 0 60 0
5 1 5005 d005 0 0000 0000 0 60 0
5 1 5006 d006 0 0000 0000 0 60 0
5 1 5007 d007 0 0000 0000 0 60 0
5 1 5008 d008 0 0000 0000 0 60 2
5 1 5009 d009 0 0000 0000 0 61 6
0 f 0000 0000 0 0000 0000 0 00 0
